//--- list.f
bf_pkg.sv
bf_hash_unit.sv
bf_counter.sv
bf_bucket_array.sv
bf_apb_regs.sv
bf_top.sv
tb_bf_top.sv

//--- Makefile
# Verilator build and run of the Bloom filter testbench

VERILATOR ?= verilator
TOP       ?= tb_bf_top
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -j 0

SRCS := bf_pkg.sv bf_hash_unit.sv bf_counter.sv bf_bucket_array.sv \
        bf_apb_regs.sv bf_top.sv tb_bf_top.sv
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# fails when the log holds the fail message or the binary exits non-zero
run: $(BIN)
	@$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q '\*\* FAIL \*\*' $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb_bf_top.sv
// testbench for the APB counting Bloom filter
// applies a table of operations over APB and checks STATUS against a model
`timescale 1ns/1ps
`default_nettype none

module tb_bf_top;

  // table operations
  localparam int OP_LOOKUP  = 0;
  localparam int OP_INSERT  = 1;
  localparam int OP_REMOVE  = 2;
  localparam int OP_CLEAR   = 3;
  localparam int OP_BOTH    = 4;
  localparam int OP_CLR_INS = 5;
  localparam int OP_DATA    = 6;
  localparam int OP_BADACC  = 7;
  // where the expected status comes from
  localparam int M_FIXED  = 0;
  localparam int M_MEMBER = 1;
  localparam int M_ALL    = 2;
  localparam logic [31:0] K1 = 32'h0000_1001;
  localparam logic [31:0] K2 = 32'h00ab_cdef;
  localparam logic [31:0] K3 = 32'hcafe_f00d;
  localparam logic [31:0] K4 = 32'h3141_5926;

  typedef struct {
    int          op;
    logic [31:0] key;
    logic        member;
    int          usage;
    logic        full;
    logic        empty;
    logic        error;
    int          mode;
  } row_t;

  logic             clk;
  logic             rst_n;
  bf_pkg::apb_req_t apb_req;
  bf_pkg::apb_rsp_t apb_rsp;

  row_t        rows[$];
  logic [31:0] cur_key;
  logic [31:0] lfsr_state = 32'h1c5b_5c0c;
  int          row_errors = 0;
  int          total_errors = 0;
  int          cycle_count = 0;
  int          cycle_limit = 100000;
  // model state
  int          mbucket[16];
  int          musage;
  logic        merror;

  bf_top DUT (
    .clk_i     (clk),
    .rst_n_i   (rst_n),
    .apb_req_i (apb_req),
    .apb_rsp_o (apb_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // run limit, set once the table is built
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("run timed out after %0d cycles", cycle_count);
      $display("** FAIL **");
      $finish;
    end
  end

  // --------------------------------------------------
  // checking and LFSR
  // --------------------------------------------------
  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error @ %0t: %s got %h, expected %h", $time, what, got, exp);
      row_errors++;
      total_errors++;
    end
  endtask

  // galois form, one step per bit
  function automatic logic lfsr_bit();
    logic out;
    out = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out) begin
      lfsr_state = lfsr_state ^ 32'h8020_0003;
    end
    return out;
  endfunction

  function automatic logic [31:0] random_key();
    logic [31:0] k;
    k = '0;
    for (int i = 0; i < 32; i++) begin
      k = {k[30:0], lfsr_bit()};
    end
    return k;
  endfunction

  // --------------------------------------------------
  // reference model
  // --------------------------------------------------
  function automatic logic [3:0] model_index(input logic [31:0] key, input int k);
    logic [31:0] x;
    logic [31:0] r;
    logic [3:0]  idx;
    int          sh;
    sh  = int'(bf_pkg::SEEDS[k].rot_amt);
    x   = key ^ bf_pkg::SEEDS[k].xor_key;
    r   = (sh == 0) ? x : ((x << sh) | (x >> (32 - sh)));
    idx = '0;
    for (int n = 0; n < 8; n++) begin
      idx = idx ^ r[4*n +: 4];
    end
    return idx;
  endfunction

  function automatic logic [15:0] model_hits(input logic [31:0] key);
    logic [15:0] hits;
    hits = '0;
    for (int k = 0; k < 3; k++) begin
      hits[model_index(key, k)] = 1'b1;
    end
    return hits;
  endfunction

  // 4-bit saturating step, sticky error on a blocked step
  function automatic int sat_step(input int v, input logic down);
    if ((down && v == 0) || (!down && v == 15)) begin
      merror = 1'b1;
      return v;
    end
    return down ? v - 1 : v + 1;
  endfunction

  function automatic void model_apply(input int op, input logic [31:0] key);
    logic [15:0] hits;
    logic        down;
    hits = model_hits(key);
    down = (op == OP_REMOVE);
    if (op == OP_INSERT || op == OP_REMOVE) begin
      for (int b = 0; b < 16; b++) begin
        if (hits[b]) begin
          mbucket[b] = sat_step(mbucket[b], down);
        end
      end
      musage = sat_step(musage, down);
    end else if (op == OP_CLEAR || op == OP_CLR_INS) begin
      for (int b = 0; b < 16; b++) begin
        mbucket[b] = 0;
      end
      musage = 0;
      merror = 1'b0;
    end
  endfunction

  // {usage, error, empty, full, member} for the given key
  function automatic logic [7:0] model_word(input logic [31:0] key);
    logic [15:0] hits;
    logic        full;
    logic        empty;
    logic        member;
    hits   = model_hits(key);
    full   = 1'b0;
    empty  = 1'b1;
    member = 1'b1;
    for (int b = 0; b < 16; b++) begin
      if (mbucket[b] == 15) full = 1'b1;
      if (mbucket[b] != 0) empty = 1'b0;
      if (hits[b] && mbucket[b] == 0) member = 1'b0;
    end
    return {4'(musage), merror, empty, full, member};
  endfunction

  // --------------------------------------------------
  // APB master, driven on the falling edge
  // --------------------------------------------------
  task automatic apb_xfer(input logic [7:0] addr, input logic wr, input logic [31:0] wdata,
                          input logic exp_err, output logic [31:0] rdata);
    @(negedge clk);
    apb_req.paddr   = addr;
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = wr;
    apb_req.pwdata  = wdata;
    @(negedge clk);
    apb_req.penable = 1'b1;
    // sampled at the access edge
    @(posedge clk);
    rdata = apb_rsp.prdata;
    check("pready", 32'(apb_rsp.pready), 32'd1);
    check($sformatf("pslverr at %h", addr), 32'(apb_rsp.pslverr), 32'(exp_err));
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, input logic exp_err);
    logic [31:0] unused;
    apb_xfer(addr, 1'b1, data, exp_err, unused);
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, input logic exp_err);
    apb_xfer(addr, 1'b0, 32'h0, exp_err, data);
  endtask

  // --------------------------------------------------
  // stimulus table
  // --------------------------------------------------
  function automatic void add_row(input int op, input logic [31:0] key, input logic member,
                                  input int usage, input logic full, input logic empty,
                                  input logic error, input int mode);
    row_t r;
    r.op     = op;
    r.key    = key;
    r.member = member;
    r.usage  = usage;
    r.full   = full;
    r.empty  = empty;
    r.error  = error;
    r.mode   = mode;
    rows.push_back(r);
  endfunction

  function automatic void build_table();
    logic [31:0] keys[20];
    // reset state
    add_row(OP_LOOKUP, 32'h0000_0000, 1'b0, 0, 1'b0, 1'b1, 1'b0, M_FIXED);
    add_row(OP_LOOKUP, 32'hdead_beef, 1'b0, 0, 1'b0, 1'b1, 1'b0, M_FIXED);
    add_row(OP_LOOKUP, K1, 1'b0, 0, 1'b0, 1'b1, 1'b0, M_FIXED);
    // inserts, no false negatives
    add_row(OP_INSERT, K1, 1'b1, 1, 1'b0, 1'b0, 1'b0, M_FIXED);
    add_row(OP_INSERT, K2, 1'b1, 2, 1'b0, 1'b0, 1'b0, M_FIXED);
    add_row(OP_INSERT, K3, 1'b1, 3, 1'b0, 1'b0, 1'b0, M_FIXED);
    add_row(OP_LOOKUP, K1, 1'b1, 3, 1'b0, 1'b0, 1'b0, M_FIXED);
    add_row(OP_LOOKUP, K2, 1'b1, 3, 1'b0, 1'b0, 1'b0, M_FIXED);
    add_row(OP_LOOKUP, 32'h7777_0001, 1'b0, 3, 1'b0, 1'b0, 1'b0, M_MEMBER);
    add_row(OP_LOOKUP, 32'h0bad_c0de, 1'b0, 3, 1'b0, 1'b0, 1'b0, M_MEMBER);
    // removals back to empty
    add_row(OP_REMOVE, K1, 1'b0, 2, 1'b0, 1'b0, 1'b0, M_MEMBER);
    add_row(OP_REMOVE, K2, 1'b0, 1, 1'b0, 1'b0, 1'b0, M_MEMBER);
    add_row(OP_REMOVE, K3, 1'b0, 0, 1'b0, 1'b1, 1'b0, M_FIXED);
    add_row(OP_LOOKUP, K1, 1'b0, 0, 1'b0, 1'b1, 1'b0, M_FIXED);
    add_row(OP_LOOKUP, K2, 1'b0, 0, 1'b0, 1'b1, 1'b0, M_FIXED);
    // saturation, then clear
    for (int i = 1; i <= 15; i++) begin
      add_row(OP_INSERT, K4, 1'b1, i, (i == 15), 1'b0, 1'b0, M_FIXED);
    end
    add_row(OP_INSERT, K4, 1'b1, 15, 1'b1, 1'b0, 1'b1, M_FIXED);
    add_row(OP_CLEAR, K4, 1'b0, 0, 1'b0, 1'b1, 1'b0, M_FIXED);
    // bus behaviour
    add_row(OP_DATA, 32'ha5a5_5a5a, 1'b0, 0, 1'b0, 1'b1, 1'b0, M_FIXED);
    add_row(OP_INSERT, K1, 1'b1, 1, 1'b0, 1'b0, 1'b0, M_FIXED);
    add_row(OP_BADACC, 32'hffff_ffff, 1'b1, 1, 1'b0, 1'b0, 1'b0, M_FIXED);
    add_row(OP_BOTH, K1, 1'b1, 1, 1'b0, 1'b0, 1'b0, M_FIXED);
    add_row(OP_BOTH, K2, 1'b0, 1, 1'b0, 1'b0, 1'b0, M_MEMBER);
    add_row(OP_CLR_INS, K2, 1'b0, 0, 1'b0, 1'b1, 1'b0, M_FIXED);
    // random keys, every field from the model
    for (int i = 0; i < 20; i++) begin
      keys[i] = random_key();
      add_row(OP_INSERT, keys[i], 1'b0, 0, 1'b0, 1'b0, 1'b0, M_ALL);
    end
    for (int i = 0; i < 10; i++) begin
      add_row(OP_REMOVE, keys[i], 1'b0, 0, 1'b0, 1'b0, 1'b0, M_ALL);
    end
  endfunction

  function automatic logic [31:0] cmd_word(input int op);
    case (op)
      OP_INSERT:  return 32'h1;
      OP_REMOVE:  return 32'h2;
      OP_BOTH:    return 32'h3;
      OP_CLEAR:   return 32'h4;
      OP_CLR_INS: return 32'h5;
      default:    return 32'h0;
    endcase
  endfunction

  function automatic string op_name(input int op);
    case (op)
      OP_LOOKUP:  return "lookup";
      OP_INSERT:  return "insert";
      OP_REMOVE:  return "remove";
      OP_CLEAR:   return "clear";
      OP_BOTH:    return "insert+remove";
      OP_CLR_INS: return "clear+insert";
      OP_DATA:    return "data readback";
      default:    return "bad access";
    endcase
  endfunction

  // each row ends with a STATUS read compared field by field
  task automatic apply_row(input row_t r);
    logic [31:0] rdata;
    logic [7:0]  mword;
    logic        exp_member;
    logic        exp_full;
    logic        exp_empty;
    logic        exp_error;
    int          exp_usage;
    case (r.op)
      OP_DATA: begin
        apb_write(bf_pkg::ADDR_DATA, r.key, 1'b0);
        cur_key = r.key;
        apb_read(bf_pkg::ADDR_DATA, rdata, 1'b0);
        check("DATA readback", rdata, r.key);
      end
      OP_BADACC: begin
        apb_write(8'h0c, r.key, 1'b1);
        apb_read(8'h10, rdata, 1'b1);
        apb_write(bf_pkg::ADDR_STATUS, 32'h7, 1'b1);
        // key register untouched by the rejected writes
        apb_read(bf_pkg::ADDR_DATA, rdata, 1'b0);
        check("DATA after bad access", rdata, cur_key);
      end
      default: begin
        apb_write(bf_pkg::ADDR_DATA, r.key, 1'b0);
        cur_key = r.key;
        apb_write(bf_pkg::ADDR_CMD, cmd_word(r.op), 1'b0);
        model_apply(r.op, r.key);
      end
    endcase
    apb_read(bf_pkg::ADDR_STATUS, rdata, 1'b0);
    mword      = model_word(cur_key);
    exp_member = (r.mode == M_FIXED) ? r.member : mword[0];
    if (r.mode == M_ALL) begin
      exp_full  = mword[1];
      exp_empty = mword[2];
      exp_error = mword[3];
      exp_usage = int'(mword[7:4]);
    end else begin
      exp_full  = r.full;
      exp_empty = r.empty;
      exp_error = r.error;
      exp_usage = r.usage;
    end
    check("member", 32'(rdata[0]), 32'(exp_member));
    check("full", 32'(rdata[1]), 32'(exp_full));
    check("empty", 32'(rdata[2]), 32'(exp_empty));
    check("error", 32'(rdata[3]), 32'(exp_error));
    check("usage", 32'(rdata[7:4]), 32'(exp_usage));
    check("status upper bits", 32'(rdata[31:8]), 32'h0);
  endtask

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------
  initial begin : proc_main
    int n_failed;
    n_failed = 0;
    apb_req  = '0;
    rst_n    = 1'b0;
    cur_key  = '0;
    model_apply(OP_CLEAR, 32'h0);
    build_table();
    // six cycles per row, plus reset and slack
    cycle_limit = rows.size() * 6 + 8 + 100;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    // idle bus response straight after reset
    @(posedge clk);
    check("prdata after reset", apb_rsp.prdata, 32'h0);
    check("pslverr after reset", 32'(apb_rsp.pslverr), 32'h0);
    check("pready after reset", 32'(apb_rsp.pready), 32'd1);
    for (int i = 0; i < rows.size(); i++) begin
      row_errors = 0;
      apply_row(rows[i]);
      $display("test %0d %s key %h: %s", i, op_name(rows[i].op), rows[i].key,
               (row_errors == 0) ? "ok" : "mismatch");
      if (row_errors != 0) n_failed++;
    end
    @(negedge clk);
    apb_req = '0;
    $display("tests %0d, failed %0d, mismatches %0d", rows.size(), n_failed, total_errors);
    if (total_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- bf_top.sv
// top level of the APB counting Bloom filter
// register block, one hash unit per seed and the bucket array
`timescale 1ns/1ps
`default_nettype none

module bf_top (
  input  wire logic        clk_i,
  input  wire logic        rst_n_i,
  input  bf_pkg::apb_req_t apb_req_i,
  output bf_pkg::apb_rsp_t apb_rsp_o
);

  // key from the data register to all hash units
  logic [bf_pkg::DATA_WIDTH-1:0]             key;
  // one one-hot per hash function
  bf_pkg::bucket_vec_t [bf_pkg::K_HASHES-1:0] hash_onehot;
  bf_pkg::bf_cmd_t                           cmd;
  bf_pkg::bf_status_t                        status;

  // ------------------------------------------------
  // register block
  // ------------------------------------------------
  bf_apb_regs i_regs (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .apb_req_i (apb_req_i),
    .apb_rsp_o (apb_rsp_o),
    .key_o     (key),
    .cmd_o     (cmd),
    .status_i  (status)
  );

  // ------------------------------------------------
  // hash units
  // ------------------------------------------------
  for (genvar g = 0; g < bf_pkg::K_HASHES; g++) begin : gen_hashes
    bf_hash_unit #(
      .SEED     (bf_pkg::SEEDS[g])
    ) i_hash (
      .key_i    (key),
      .onehot_o (hash_onehot[g])
    );
  end

  // ------------------------------------------------
  // buckets
  // ------------------------------------------------
  bf_bucket_array i_buckets (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .hash_i   (hash_onehot),
    .cmd_i    (cmd),
    .status_o (status)
  );

endmodule

`default_nettype wire

//--- bf_apb_regs.sv
// APB slave of the filter: key register, command pulse and status readback
// pready is tied high, so every transfer ends in its access cycle
`timescale 1ns/1ps
`default_nettype none

module bf_apb_regs (
  input  wire logic                          clk_i,
  input  wire logic                          rst_n_i,
  input  bf_pkg::apb_req_t                   apb_req_i,
  output bf_pkg::apb_rsp_t                   apb_rsp_o,
  output logic [bf_pkg::DATA_WIDTH-1:0]      key_o,
  output bf_pkg::bf_cmd_t                    cmd_o,
  input  bf_pkg::bf_status_t                 status_i
);

  // access phase qualifiers
  logic access;
  logic wr_access;
  logic rd_access;
  // address decode
  logic sel_data;
  logic sel_cmd;
  logic sel_status;
  logic addr_ok;
  logic apb_err;
  // registers
  logic [bf_pkg::DATA_WIDTH-1:0] key_q;
  bf_pkg::bf_cmd_t               cmd_d;
  bf_pkg::bf_cmd_t               cmd_q;
  logic [bf_pkg::DATA_WIDTH-1:0] rd_data;

  // ------------------------------------------------
  // decode
  // ------------------------------------------------
  assign access     = apb_req_i.psel & apb_req_i.penable;
  assign sel_data   = (apb_req_i.paddr == bf_pkg::ADDR_DATA);
  assign sel_cmd    = (apb_req_i.paddr == bf_pkg::ADDR_CMD);
  assign sel_status = (apb_req_i.paddr == bf_pkg::ADDR_STATUS);
  assign addr_ok    = sel_data | sel_cmd | sel_status;

  // unmapped address or write to the read-only status
  assign apb_err    = access & (~addr_ok | (apb_req_i.pwrite & sel_status));

  // erroneous accesses have no side effect
  assign wr_access  = access & apb_req_i.pwrite & ~apb_err;
  assign rd_access  = access & ~apb_req_i.pwrite & ~apb_err;

  // ------------------------------------------------
  // command encoding
  // ------------------------------------------------
  // clear dominates, insert together with remove is dropped
  always_comb begin : proc_cmd_decode
    cmd_d        = '0;
    cmd_d.clear  = apb_req_i.pwdata[2];
    cmd_d.insert = apb_req_i.pwdata[0] & ~apb_req_i.pwdata[1] & ~apb_req_i.pwdata[2];
    cmd_d.remove = apb_req_i.pwdata[1] & ~apb_req_i.pwdata[0] & ~apb_req_i.pwdata[2];
  end

  // ------------------------------------------------
  // registers
  // ------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      key_q <= '0;
    end else if (wr_access && sel_data) begin
      key_q <= apb_req_i.pwdata;
    end
  end

  // pulse for one cycle after the access edge
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cmd_q <= '0;
    end else if (wr_access && sel_cmd) begin
      cmd_q <= cmd_d;
    end else begin
      cmd_q <= '0;
    end
  end

  // ------------------------------------------------
  // read data
  // ------------------------------------------------
  always_comb begin : proc_read_mux
    rd_data = '0;
    if (rd_access) begin
      if (sel_data) begin
        rd_data = key_q;
      end else if (sel_status) begin
        // status word zero extended, CMD reads back as zero
        rd_data = {{(bf_pkg::DATA_WIDTH - $bits(bf_pkg::bf_status_t)){1'b0}}, status_i};
      end
    end
  end

  assign apb_rsp_o.prdata  = rd_data;
  assign apb_rsp_o.pready  = 1'b1;
  assign apb_rsp_o.pslverr = apb_err;

  assign key_o = key_q;
  assign cmd_o = cmd_q;

endmodule

`default_nettype wire

//--- bf_bucket_array.sv
// bucket counters, item counter and status flags of the Bloom filter
// takes the hash one-hots and the command pulse, returns the status word
`timescale 1ns/1ps
`default_nettype none

module bf_bucket_array (
  input  wire logic                                 clk_i,
  input  wire logic                                 rst_n_i,
  input  bf_pkg::bucket_vec_t [bf_pkg::K_HASHES-1:0] hash_i,
  input  bf_pkg::bf_cmd_t                           cmd_i,
  output bf_pkg::bf_status_t                        status_o
);

  // buckets picked by the current key
  bf_pkg::bucket_vec_t indicator;
  // per-bucket counter control
  bf_pkg::bucket_vec_t bucket_en;
  logic                step;
  logic                step_down;
  // per-bucket state
  bf_pkg::bucket_cnt_t [bf_pkg::NUM_BUCKETS-1:0] bucket_cnt;
  bf_pkg::bucket_vec_t bucket_nonzero;
  bf_pkg::bucket_vec_t bucket_at_max;
  bf_pkg::bucket_vec_t bucket_ovf;
  // item counter
  bf_pkg::usage_cnt_t  usage;
  logic                usage_ovf;

  // ------------------------------------------------
  // indicator vector
  // ------------------------------------------------
  always_comb begin : proc_indicator
    indicator = '0;
    for (int unsigned j = 0; j < bf_pkg::K_HASHES; j++) begin
      indicator = indicator | hash_i[j];
    end
  end

  // exactly one of insert/remove steps the counters
  assign step      = cmd_i.insert ^ cmd_i.remove;
  assign step_down = cmd_i.remove;
  assign bucket_en = step ? indicator : '0;

  // ------------------------------------------------
  // bucket counters
  // ------------------------------------------------
  for (genvar i = 0; i < bf_pkg::NUM_BUCKETS; i++) begin : gen_buckets
    bf_counter #(
      .count_t    (bf_pkg::bucket_cnt_t)
    ) i_bucket (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .clear_i    (cmd_i.clear),
      .en_i       (bucket_en[i]),
      .down_i     (step_down),
      .count_o    (bucket_cnt[i]),
      .overflow_o (bucket_ovf[i])
    );
    assign bucket_nonzero[i] = |bucket_cnt[i];
    assign bucket_at_max[i]  = &bucket_cnt[i];
  end

  // ------------------------------------------------
  // item counter
  // ------------------------------------------------
  // one step per insert or remove, same direction as the buckets
  bf_counter #(
    .count_t    (bf_pkg::usage_cnt_t)
  ) i_usage (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .clear_i    (cmd_i.clear),
    .en_i       (step),
    .down_i     (step_down),
    .count_o    (usage),
    .overflow_o (usage_ovf)
  );

  // ------------------------------------------------
  // lookup and flags
  // ------------------------------------------------
  // member only if every indicated bucket holds something
  assign status_o.member = ((indicator & bucket_nonzero) == indicator);
  assign status_o.full   = |bucket_at_max;
  assign status_o.empty  = ~|bucket_nonzero;
  // any sticky overflow anywhere
  assign status_o.error  = (|bucket_ovf) | usage_ovf;
  assign status_o.usage  = usage;

endmodule

`default_nettype wire

//--- bf_counter.sv
// saturating up/down counter with a sticky overflow flag
// count_t selects the width, used for the bucket and the item counters
`timescale 1ns/1ps
`default_nettype none

module bf_counter #(
  parameter type count_t = logic [3:0]
) (
  input  wire logic clk_i,
  input  wire logic rst_n_i,
  input  wire logic clear_i,
  input  wire logic en_i,
  input  wire logic down_i,
  output count_t    count_o,
  output logic      overflow_o
);

  count_t count_q;
  logic   overflow_q;
  // count sitting at one of the saturation limits
  logic   at_max;
  logic   at_zero;

  assign at_max  = &count_q;
  assign at_zero = ~|count_q;

  // ------------------------------------------------
  // counter and sticky overflow
  // ------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i || clear_i) begin
      count_q    <= '0;
      overflow_q <= 1'b0;
    end else if (en_i) begin
      if (down_i) begin
        // hold at zero, flag the underflow
        if (at_zero) begin
          overflow_q <= 1'b1;
        end else begin
          count_q <= count_t'(count_q - 1'b1);
        end
      end else begin
        // hold at max, flag the overflow
        if (at_max) begin
          overflow_q <= 1'b1;
        end else begin
          count_q <= count_t'(count_q + 1'b1);
        end
      end
    end
  end

  assign count_o    = count_q;
  assign overflow_o = overflow_q;

endmodule

`default_nettype wire

//--- bf_hash_unit.sv
// one seeded hash of the filter key into a one-hot bucket vector
// instantiated once per hash function, each with its own seed
`timescale 1ns/1ps
`default_nettype none

module bf_hash_unit #(
  parameter bf_pkg::bf_seed_t SEED = bf_pkg::SEEDS[0]
) (
  input  wire logic [bf_pkg::DATA_WIDTH-1:0] key_i,
  output bf_pkg::bucket_vec_t                onehot_o
);

  // key mixed with the seed, then rotated
  logic [bf_pkg::DATA_WIDTH-1:0]   mixed;
  logic [2*bf_pkg::DATA_WIDTH-1:0] doubled;
  logic [bf_pkg::DATA_WIDTH-1:0]   rotated;
  logic [bf_pkg::HASH_WIDTH-1:0]   index;

  // substitution step
  assign mixed = key_i ^ SEED.xor_key;

  // left rotate via a doubled copy
  // the upper half wraps the bits shifted out of the lower copy
  assign doubled = {mixed, mixed} << SEED.rot_amt;
  assign rotated = doubled[2*bf_pkg::DATA_WIDTH-1:bf_pkg::DATA_WIDTH];

  // fold all nibbles down to one bucket index
  always_comb begin : proc_fold
    index = '0;
    for (int unsigned i = 0; i < bf_pkg::DATA_WIDTH / bf_pkg::HASH_WIDTH; i++) begin
      index = index ^ rotated[i*bf_pkg::HASH_WIDTH +: bf_pkg::HASH_WIDTH];
    end
  end

  // index to one-hot
  always_comb begin : proc_onehot
    onehot_o        = '0;
    onehot_o[index] = 1'b1;
  end

endmodule

`default_nettype wire

//--- bf_pkg.sv
// shared sizes, hash seeds, bus and command structs and the register map
// for the APB counting Bloom filter; every block refers to it by scoped name
`default_nettype none

package bf_pkg;

  // ------------------------------------------------
  // sizes
  // ------------------------------------------------
  localparam int unsigned DATA_WIDTH   = 32;
  localparam int unsigned HASH_WIDTH   = 4;
  localparam int unsigned NUM_BUCKETS  = 2**HASH_WIDTH;
  localparam int unsigned K_HASHES     = 3;
  localparam int unsigned BUCKET_WIDTH = 4;

  typedef logic [BUCKET_WIDTH-1:0] bucket_cnt_t;
  // item count is sized from the index width
  typedef logic [HASH_WIDTH-1:0]   usage_cnt_t;
  typedef logic [NUM_BUCKETS-1:0]  bucket_vec_t;

  // ------------------------------------------------
  // hash seeds
  // ------------------------------------------------
  typedef struct packed {
    logic [DATA_WIDTH-1:0] xor_key;
    logic [4:0]            rot_amt;
  } bf_seed_t;

  // one seed per hash unit, index 0 is the rightmost entry
  localparam bf_seed_t [K_HASHES-1:0] SEEDS = '{
    '{xor_key: 32'h5a17_c3e9, rot_amt: 5'd19},
    '{xor_key: 32'h9e37_79b9, rot_amt: 5'd11},
    '{xor_key: 32'h2f6b_0d14, rot_amt: 5'd5}
  };

  // ------------------------------------------------
  // APB bus
  // ------------------------------------------------
  typedef struct packed {
    logic [7:0]            paddr;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [DATA_WIDTH-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [DATA_WIDTH-1:0] prdata;
    logic                  pready;
    logic                  pslverr;
  } apb_rsp_t;

  // filter command, one cycle wide
  typedef struct packed {
    logic clear;
    logic remove;
    logic insert;
  } bf_cmd_t;

  // member lands in bit 0, usage in bits 7:4
  typedef struct packed {
    usage_cnt_t usage;
    logic       error;
    logic       empty;
    logic       full;
    logic       member;
  } bf_status_t;

  // register offsets
  localparam logic [7:0] ADDR_DATA   = 8'h00;
  localparam logic [7:0] ADDR_CMD    = 8'h04;
  localparam logic [7:0] ADDR_STATUS = 8'h08;

endpackage

`default_nettype wire
